// File: logic/score_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module score_keeper (
    input  logic              clk,
    input  logic              rst,
    input  logic              result_valid,
    input  logic              result_ready,
    input  logic              result_hit,
    output throw_pkg::count_t throws,
    output throw_pkg::count_t hits
);

    import throw_pkg::*;

    localparam count_t COUNT_MAX = '1;

    logic accept;

    function automatic count_t sat_inc(input count_t c);
        if (c == COUNT_MAX) begin
            return c;
        end
        return c + 1'b1;
    endfunction

    assign accept = result_valid && result_ready;   // Result handshake

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            throws <= '0;
            hits   <= '0;
        end else begin
            if (accept) begin
                throws <= sat_inc(throws);
                if (result_hit) begin
                    hits <= sat_inc(hits);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/throw_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module throw_ctl (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick,
    input  logic              launch_valid,
    input  throw_pkg::force_t launch_force,
    input  throw_pkg::wind_t  launch_wind,
    output logic              launch_ready,
    output throw_pkg::pos_t   x_pos,
    output throw_pkg::pos_t   y_pos,
    output logic              result_valid,
    output logic              result_hit,
    output logic              result_wall,
    input  logic              result_ready
);

    import throw_pkg::*;

    localparam int POS_MAX = 2 ** ($bits(pos_t) - 1) - 1;
    localparam int POS_MIN = -POS_MAX - 1;

    typedef enum logic [1:0] {IDLE, THROW, FALL, END} state_t;

    state_t state;

    force_t     force_r;
    wind_t      wind_r;
    logic [6:0] n_cnt;      // Ticks since launch
    logic [6:0] m_cnt;      // Ticks since apex
    logic       step;       // Position update the cycle after a tick
    pos_t       apex_x;
    pos_t       apex_y;

    int   wind_effect;
    int   drift;
    int   cand_x;
    int   cand_y;
    pos_t next_x;
    pos_t next_y;
    logic hold_x;
    logic at_apex;
    logic wall_end;
    logic floor_end;
    logic in_target;

    // Saturate instead of wrapping far throws back onto the screen
    function automatic pos_t to_pos(input int v);
        if (v > POS_MAX) begin
            return pos_t'(POS_MAX);
        end else if (v < POS_MIN) begin
            return pos_t'(POS_MIN);
        end
        return pos_t'(v);
    endfunction

    function automatic int row_of(input pos_t y);
        return VER_PIXELS - int'(y);
    endfunction

    function automatic logic in_wall_x(input pos_t x);
        return (int'(x) >= WALL_X_LEFT - WALL_MARGIN) &&
               (int'(x) <= WALL_X_RIGHT + WALL_MARGIN);
    endfunction

    assign launch_ready = (state == IDLE);
    assign result_valid = (state == END);

    always_comb begin
        if (wind_r > 7'd50) begin
            wind_effect = -5 - (int'(wind_r) - 50) / 8;   // Headwind
        end else if (wind_r < 7'd50) begin
            wind_effect = 5 + (50 - int'(wind_r)) / 8;    // Tailwind
        end else begin
            wind_effect = 0;
        end
        drift = ((int'(force_r) * FORCE_SCALE) >>> 6) + wind_effect;
    end

    always_comb begin
        if (state == FALL) begin
            cand_y = int'(apex_y) - (GRAVITY * int'(m_cnt) * int'(m_cnt)) / 2;
            cand_x = int'(apex_x) + drift * int'(m_cnt);
        end else begin
            cand_y = LAUNCH_Y + INITIAL_VELOCITY * int'(n_cnt)
                     - (GRAVITY * int'(n_cnt) * int'(n_cnt)) / 2;
            cand_x = LAUNCH_X + drift * int'(n_cnt);
        end
    end

    always_comb begin
        // Below the wall top and inside its span, x is stuck
        hold_x = (row_of(y_pos) > WALL_TOP) && in_wall_x(x_pos);
        next_x = hold_x ? x_pos : to_pos(cand_x);
        next_y = to_pos(cand_y);

        at_apex   = (state == THROW) &&
                    (INITIAL_VELOCITY - GRAVITY * int'(n_cnt) <= 0);
        wall_end  = (row_of(next_y) <= WALL_TOP) &&
                    (row_of(next_y) >= WALL_TOP - WALL_MARGIN) &&
                    in_wall_x(next_x);
        floor_end = (int'(next_y) <= FLOOR_Y);
        in_target = (row_of(next_y) >= TARGET_TOP) &&
                    (row_of(next_y) <= TARGET_BOTTOM) &&
                    (int'(next_x) >= TARGET_X_LEFT) &&
                    (int'(next_x) <= TARGET_X_RIGHT);
    end

    always_ff @(posedge clk) begin
        if (launch_valid && launch_ready) begin
            force_r <= launch_force;
            wind_r  <= launch_wind;
        end
        if (step && at_apex) begin
            apex_x <= next_x;
            apex_y <= next_y;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            n_cnt       <= '0;
            m_cnt       <= '0;
            step        <= 1'b0;
            x_pos       <= pos_t'(LAUNCH_X);
            y_pos       <= pos_t'(LAUNCH_Y);
            result_hit  <= 1'b0;
            result_wall <= 1'b0;
        end else begin
            step <= tick && (state == THROW || state == FALL);
            case (state)
                IDLE: begin
                    x_pos <= pos_t'(LAUNCH_X);
                    y_pos <= pos_t'(LAUNCH_Y);
                    if (launch_valid && launch_ready) begin
                        state       <= THROW;
                        n_cnt       <= '0;
                        result_hit  <= 1'b0;
                        result_wall <= 1'b0;
                    end
                end
                THROW, FALL: begin
                    if (step) begin
                        x_pos <= next_x;
                        y_pos <= next_y;
                        if (in_target) begin
                            result_hit <= 1'b1;   // Sticky over the flight
                        end
                        if (wall_end || floor_end) begin
                            state       <= END;
                            result_wall <= wall_end;
                            x_pos       <= pos_t'(LAUNCH_X);
                            y_pos       <= pos_t'(LAUNCH_Y);
                        end else if (at_apex) begin
                            state <= FALL;
                            m_cnt <= '0;
                        end
                    end else if (tick) begin
                        if (state == THROW) begin
                            n_cnt <= n_cnt + 7'd1;
                        end else begin
                            m_cnt <= m_cnt + 7'd1;
                        end
                    end
                end
                END: begin
                    if (result_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/throw_game.sv
`timescale 1ns/1ps
`default_nettype none

module throw_game #(
    parameter int TICK_DIV = 1000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              launch_valid,
    input  throw_pkg::force_t launch_force,
    input  throw_pkg::wind_t  launch_wind,
    output logic              launch_ready,
    output throw_pkg::pos_t   x_pos,
    output throw_pkg::pos_t   y_pos,
    output logic              result_valid,
    output logic              result_hit,
    output logic              result_wall,
    input  logic              result_ready,
    output throw_pkg::count_t throws,
    output throw_pkg::count_t hits
);

    logic tick;

    tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) i_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    throw_ctl i_throw_ctl (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .launch_valid (launch_valid),
        .launch_force (launch_force),
        .launch_wind  (launch_wind),
        .launch_ready (launch_ready),
        .x_pos        (x_pos),
        .y_pos        (y_pos),
        .result_valid (result_valid),
        .result_hit   (result_hit),
        .result_wall  (result_wall),
        .result_ready (result_ready)
    );

    // Sees the same handshake as the controller
    score_keeper i_score_keeper (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_hit   (result_hit),
        .throws       (throws),
        .hits         (hits)
    );

endmodule

`default_nettype wire

// File: logic/throw_pkg.sv
`default_nettype none

package throw_pkg;

    typedef logic signed [11:0] pos_t;   // Y grows upward from bottom edge
    typedef logic [9:0]         force_t;
    typedef logic [6:0]         wind_t;  // 50 is calm
    typedef logic [7:0]         count_t;

    localparam int VER_PIXELS = 768;

    // Launch point and start conditions
    localparam int LAUNCH_X         = 140;
    localparam int LAUNCH_Y         = 350;
    localparam int INITIAL_VELOCITY = 27;
    localparam int GRAVITY          = 1;
    localparam int FORCE_SCALE      = 18;  // Applied as (force * this) >> 6

    localparam int FLOOR_Y = 190;          // Flight ends at or below

    // Wall top given as a screen row
    localparam int WALL_X_LEFT  = 490;
    localparam int WALL_X_RIGHT = 534;
    localparam int WALL_TOP     = 241;
    localparam int WALL_MARGIN  = 15;

    // Target box in downward screen rows
    localparam int TARGET_X_LEFT  = 867;
    localparam int TARGET_X_RIGHT = 1024;
    localparam int TARGET_TOP     = 427;
    localparam int TARGET_BOTTOM  = 525;

endpackage

`default_nettype wire

// File: logic/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
    parameter int TICK_DIV = 1000
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 2) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // Tick lands on the clock after the wrap value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (cnt == CNT_W'(TICK_DIV - 1)) begin
                cnt  <= '0;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt + 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: project.f
logic/throw_pkg.sv
logic/tick_gen.sv
logic/throw_ctl.sv
logic/score_keeper.sv
logic/throw_game.sv
tb/tb_clock.sv
tb/tb_throw_game.sv

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int CYCLE_NS     = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(CYCLE_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);   // Release away from the active edge
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/tb_throw_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_throw_game;

    import throw_pkg::*;

    localparam int TICK_DIV    = 4;
    localparam int FLIGHTS     = 12;
    localparam int LONGEST     = (2 * INITIAL_VELOCITY + 30) * TICK_DIV;
    localparam int CYCLE_LIMIT = FLIGHTS * LONGEST + 200;
    localparam int MAX_TICKS   = 128;

    logic   clk;
    logic   rst;
    logic   launch_valid;
    force_t launch_force;
    wind_t  launch_wind;
    logic   launch_ready;
    pos_t   x_pos;
    pos_t   y_pos;
    logic   result_valid;
    logic   result_hit;
    logic   result_wall;
    logic   result_ready;
    count_t throws;
    count_t hits;

    int          exp_x [MAX_TICKS];
    int          exp_y [MAX_TICKS];
    int          exp_n;
    logic        exp_hit;
    logic        exp_wall;
    int          exp_throws = 0;
    int          exp_hits = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycles = 0;
    int          steps;
    logic        tick_d1;
    logic        tick_d2;
    string       test_name = "none";
    logic [31:0] lfsr = 32'h7ec4;

    tb_clock #(.CYCLE_NS(4), .RESET_CYCLES(8)) i_tb_clock (.clk(clk), .rst(rst));

    throw_game #(.TICK_DIV(TICK_DIV)) i_throw_game (
        .clk(clk), .rst(rst), .launch_valid(launch_valid), .launch_force(launch_force),
        .launch_wind(launch_wind), .launch_ready(launch_ready), .x_pos(x_pos), .y_pos(y_pos),
        .result_valid(result_valid), .result_hit(result_hit), .result_wall(result_wall),
        .result_ready(result_ready), .throws(throws), .hits(hits)
    );

    function automatic int clip_pos(input int v);
        if (v > 2047) begin
            return 2047;
        end else if (v < -2048) begin
            return -2048;
        end
        return v;
    endfunction

    function automatic int wind_push(input int w);
        if (w > 50) begin
            return -5 - (w - 50) / 8;
        end else if (w < 50) begin
            return 5 + (50 - w) / 8;
        end
        return 0;
    endfunction

    function automatic logic over_wall(input int x);
        return (x >= WALL_X_LEFT - WALL_MARGIN) && (x <= WALL_X_RIGHT + WALL_MARGIN);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic draw_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // Walks ticks 1..n of the flight with x held beside the wall
    task automatic predict_flight(input int f, input int w);
        int   drift;
        int   x;
        int   y;
        int   row;
        int   apex_x;
        int   apex_y;
        int   m;
        int   k;
        logic falling;
        logic hold;
        logic done;
        drift    = ((f * FORCE_SCALE) >>> 6) + wind_push(w);
        x        = LAUNCH_X;
        y        = LAUNCH_Y;
        apex_x   = 0;
        apex_y   = 0;
        m        = 0;
        k        = 0;
        falling  = 1'b0;
        done     = 1'b0;
        exp_hit  = 1'b0;
        exp_wall = 1'b0;
        exp_n    = 0;
        while (!done && k < MAX_TICKS - 1) begin
            k++;
            hold = (VER_PIXELS - y > WALL_TOP) && over_wall(x);
            if (falling) begin
                m++;
                x = hold ? x : clip_pos(apex_x + drift * m);
                y = clip_pos(apex_y - (GRAVITY * m * m) / 2);
            end else begin
                x = hold ? x : clip_pos(LAUNCH_X + drift * k);
                y = clip_pos(LAUNCH_Y + INITIAL_VELOCITY * k - (GRAVITY * k * k) / 2);
            end
            row      = VER_PIXELS - y;
            exp_x[k] = x;
            exp_y[k] = y;
            exp_n    = k;
            if (row >= TARGET_TOP && row <= TARGET_BOTTOM &&
                x >= TARGET_X_LEFT && x <= TARGET_X_RIGHT) begin
                exp_hit = 1'b1;
            end
            if (row <= WALL_TOP && row >= WALL_TOP - WALL_MARGIN && over_wall(x)) begin
                exp_wall = 1'b1;
                done     = 1'b1;
            end else if (y <= FLOOR_Y) begin
                done = 1'b1;
            end else if (!falling && INITIAL_VELOCITY - GRAVITY * k <= 0) begin
                falling = 1'b1;   // Apex reached
                apex_x  = x;
                apex_y  = y;
            end
        end
    endtask

    // Mode 0 wants a hit, 1 a wall stop, 2 a plain floor landing
    task automatic find_force(input int mode, input int first, output int found);
        found = -1;
        for (int f = first; f < 1024 && found < 0; f++) begin
            predict_flight(f, 50);
            if ((mode == 0 && exp_hit && !exp_wall) || (mode == 1 && exp_wall) ||
                (mode == 2 && !exp_hit && !exp_wall)) begin
                found = f;
            end
        end
        assert (found >= 0) else begin
            $display("%s: no calm-wind force gives the wanted outcome", test_name);
            errors++;
        end
    endtask

    task automatic run_flight(input int f, input int w, input int stall);
        logic hit_seen;
        logic wall_seen;
        predict_flight(f, w);
        while (!launch_ready) @(negedge clk);
        launch_force = force_t'(f);
        launch_wind  = wind_t'(w);
        launch_valid = 1'b1;
        @(negedge clk);
        launch_valid = 1'b0;
        while (!result_valid) @(negedge clk);
        hit_seen  = result_hit;
        wall_seen = result_wall;
        assert (result_hit == exp_hit) else begin
            $display("MISMATCH %s result_hit expected %0b actual %0b", test_name, exp_hit,
                     result_hit);
            errors++;
        end
        assert (result_wall == exp_wall) else begin
            $display("MISMATCH %s result_wall expected %0b actual %0b", test_name, exp_wall,
                     result_wall);
            errors++;
        end
        repeat (stall) begin
            @(negedge clk);
            assert (result_valid && !launch_ready &&
                    result_hit == hit_seen && result_wall == wall_seen) else begin
                $display("%s: result changed or launch reopened while held", test_name);
                errors++;
            end
        end
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        exp_throws++;
        exp_hits += exp_hit ? 1 : 0;
        assert (launch_ready && !result_valid) else begin
            $display("MISMATCH %s ready/valid after result expected 1/0 actual %0b/%0b",
                     test_name, launch_ready, result_valid);
            errors++;
        end
        assert (throws == exp_throws && hits == exp_hits) else begin
            $display("MISMATCH %s throws/hits expected %0d/%0d actual %0d/%0d", test_name,
                     exp_throws, exp_hits, throws, hits);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            n_pass++;
            $display("test %s: ok", test_name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // Position lands two clocks after the tick that stepped it
    always @(negedge clk) begin
        if (rst) begin
            steps   = 0;
            tick_d1 = 1'b0;
            tick_d2 = 1'b0;
        end else begin
            if (tick_d2) begin
                steps++;
                assert (steps <= exp_n) else begin
                    $display("%s: flight went on past step %0d", test_name, exp_n);
                    errors++;
                end
                if (steps <= exp_n && !result_valid) begin
                    assert (x_pos == exp_x[steps]) else begin
                        $display("MISMATCH %s x at step %0d expected %0d actual %0d",
                                 test_name, steps, exp_x[steps], x_pos);
                        errors++;
                    end
                    assert (y_pos == exp_y[steps]) else begin
                        $display("MISMATCH %s y at step %0d expected %0d actual %0d",
                                 test_name, steps, exp_y[steps], y_pos);
                        errors++;
                    end
                end else if (result_valid) begin
                    assert (steps == exp_n) else begin
                        $display("MISMATCH %s flight steps expected %0d actual %0d",
                                 test_name, exp_n, steps);
                        errors++;
                    end
                end
            end
            tick_d2 = tick_d1;
            tick_d1 = i_throw_game.tick && !launch_ready && !result_valid;
            if (launch_ready) begin
                steps = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped at cycle %0d before the tests finished", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int hit_f;
        int wall_f;
        int floor_f;
        int f;
        int w;
        launch_valid = 1'b0;
        launch_force = '0;
        launch_wind  = wind_t'(50);
        result_ready = 1'b0;
        @(negedge rst);
        @(negedge clk);

        begin_test("reset");
        assert (launch_ready && !result_valid) else begin
            $display("MISMATCH %s ready/valid expected 1/0 actual %0b/%0b", test_name,
                     launch_ready, result_valid);
            errors++;
        end
        assert (x_pos == LAUNCH_X && y_pos == LAUNCH_Y) else begin
            $display("MISMATCH %s x/y expected %0d/%0d actual %0d/%0d", test_name,
                     LAUNCH_X, LAUNCH_Y, x_pos, y_pos);
            errors++;
        end
        assert (throws == 0 && hits == 0) else begin
            $display("MISMATCH %s throws/hits expected 0/0 actual %0d/%0d", test_name,
                     throws, hits);
            errors++;
        end
        end_test();

        begin_test("shape calm");
        run_flight(100, 50, 0);
        end_test();
        begin_test("shape headwind");
        run_flight(100, 90, 0);
        end_test();
        begin_test("shape tailwind");
        run_flight(100, 10, 0);
        end_test();

        begin_test("target hit");
        find_force(0, 0, hit_f);
        if (hit_f >= 0) begin
            run_flight(hit_f, 50, 0);
        end
        end_test();
        begin_test("wall stop");
        find_force(1, 0, wall_f);
        if (wall_f >= 0) begin
            run_flight(wall_f, 50, 0);
        end
        end_test();
        begin_test("floor landing");
        find_force(2, wall_f + 1, floor_f);
        if (floor_f >= 0) begin
            run_flight(floor_f, 50, 0);
        end
        end_test();

        begin_test("back-pressure");
        run_flight(100, 50, 12);
        end_test();

        begin_test("random");
        repeat (4) begin
            draw_bits(8, f);
            draw_bits(7, w);
            run_flight(f, w, 0);
        end
        end_test();

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (errors == 0 && n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
